// ==== src.f ====
+incdir+include
hdl/pin_link_pkg.sv
hdl/down_word_fifo.sv
hdl/core_to_pin.sv
hdl/pin_to_core.sv
hdl/pin_link_top.sv
test/pin_link_properties.sv
test/tb_pin_link.sv

// ==== Makefile ====
# Verilator build and run of the pin link testbench

VERILATOR ?= verilator
TOP       ?= tb_pin_link
BUILD_DIR ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

SIM_BIN := $(BUILD_DIR)/$(TOP)
SOURCES := $(wildcard include/*.svh hdl/*.sv test/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

# pass only if the pass message shows up on a line of its own
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_pin_link.sv ====
`timescale 1ns/1ns
`include "pin_widths.svh"

module tb_pin_link;

  import pin_link_pkg::*;

  localparam int unsigned FIFO_DEPTH     = 4;
  localparam int unsigned STARTUP_CYCLES = 20;
  localparam int unsigned N_WORDS        = 200;  // per direction
  localparam int unsigned BP_WORDS       = 8;    // more than the downlink can hold
  localparam int unsigned BP_CYCLES      = 30;   // ready held low this long
  localparam int unsigned WORST_CYCLES   = 60;   // per word, worst case
  localparam int unsigned SEED           = 32'h55f9582a;
  localparam int unsigned PERIOD         = 10;
  localparam longint      WATCHDOG_NS    = (N_WORDS * WORST_CYCLES + STARTUP_CYCLES) * PERIOD;

  logic       clk;
  logic       reset;
  down_chan_t core_down;
  logic       core_down_ack;
  down_pins_t down_pins;
  logic       down_ready;
  up_pins_t   up_pins;
  logic       up_ready;
  up_chan_t   core_up;
  logic       core_up_ack;

  logic [`DOWN_BITS-1:0] down_q[$]; // words acked to the core, oldest first
  logic [`UP_BITS-1:0]   up_q[$];   // words put on the uplink pins
  int                    errors;
  int                    test_errs [1:5];
  int                    pin_words;   // rises of valid seen on the downlink pins
  logic                  valid_seen;  // down_pins.valid one cycle back
  int                    failed;

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  pin_link_top #(
    .FIFO_DEPTH     (FIFO_DEPTH),
    .STARTUP_CYCLES (STARTUP_CYCLES)
  ) i_dut (
    .clk           (clk),
    .reset         (reset),
    .core_down     (core_down),
    .core_down_ack (core_down_ack),
    .down_pins     (down_pins),
    .down_ready    (down_ready),
    .up_pins       (up_pins),
    .up_ready      (up_ready),
    .core_up       (core_up),
    .core_up_ack   (core_up_ack)
  );

  // pin side word counter, independent of the chip model
  always @(posedge clk) begin
    #1;
    if (!reset && down_pins.valid && !valid_seen) begin
      pin_words++;
    end
    valid_seen = down_pins.valid;
  end

  task automatic note_mismatch(input int test_id, input string sig,
                               input logic [63:0] got, input logic [63:0] exp);
    errors++;
    test_errs[test_id]++;
    $display("[ERROR] t=%0t test %0d %s: got %h, expected %h", $time, test_id, sig, got, exp);
  endtask

  task automatic note_failure(input int test_id, input string what);
    errors++;
    test_errs[test_id]++;
    $display("t=%0t test %0d: %s", $time, test_id, what);
  endtask

  // all reads and drives happen 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // core side downlink producer, one word per ack
  task automatic offer_word(input int gap);
    logic [DOWN_BITS-1:0] w;
    w = DOWN_BITS'($urandom);
    repeat (gap) next_cycle();
    core_down.v = 1'b1;
    core_down.d = w;
    do next_cycle(); while (!core_down_ack);
    down_q.push_back(w); // acked, must show up on the pins
    core_down.v = 1'b0;
    core_down.d = DOWN_BITS'($urandom); // junk while idle
  endtask

  // chip downlink model, level handshake
  task automatic take_down_word(input int test_id, input int delay);
    logic [DOWN_BITS-1:0] exp;
    repeat (delay) next_cycle();
    down_ready = 1'b1;
    do next_cycle(); while (!down_pins.valid);
    if (down_q.size() == 0) begin
      note_failure(test_id, "downlink valid rose with no acknowledged word pending");
    end else begin
      exp = down_q.pop_front();
      if (down_pins.data !== exp) begin
        note_mismatch(test_id, "down_pins.data", 64'(down_pins.data), 64'(exp));
      end
    end
    down_ready = 1'b0; // word taken
    next_cycle();
    if (down_pins.valid) begin
      note_failure(test_id, "downlink valid still high one cycle after ready fell");
    end
  endtask

  task automatic check_startup();
    for (int i = 0; i < STARTUP_CYCLES; i++) begin
      if (up_ready) begin
        note_failure(3, "up_ready high inside the startup interval");
      end
      next_cycle();
    end
  endtask

  // chip uplink model, holds the word until ready falls
  task automatic drive_up_word(input int gap);
    logic [UP_BITS-1:0] w;
    w = UP_BITS'({$urandom, $urandom});
    repeat (gap) next_cycle();
    while (!up_ready) next_cycle();
    up_pins.valid = 1'b1;
    up_pins.data  = w;
    up_q.push_back(w); // queued before capture, no race with the core side
    do next_cycle(); while (up_ready);
    up_pins.valid = 1'b0;
    up_pins.data  = UP_BITS'({$urandom, $urandom}); // stale capture would show
  endtask

  // core uplink consumer, late one-cycle ack
  task automatic accept_up_word(input int delay);
    logic [UP_BITS-1:0] held;
    logic [UP_BITS-1:0] exp;
    while (!core_up.v) next_cycle();
    held = core_up.d;
    if (up_q.size() == 0) begin
      note_failure(4, "core_up.v high with no chip word pending");
    end else begin
      exp = up_q.pop_front();
      if (held !== exp) begin
        note_mismatch(4, "core_up.d", 64'(held), 64'(exp));
      end
    end
    if (up_ready) begin
      note_failure(4, "up_ready high while a word waits for its acknowledge");
    end
    repeat (delay) begin
      next_cycle();
      if (!core_up.v) begin
        note_failure(4, "core_up.v dropped before the acknowledge");
      end
      if (core_up.d !== held) begin
        note_mismatch(4, "core_up.d", 64'(core_up.d), 64'(held));
      end
      if (up_ready) begin
        note_failure(4, "up_ready high while a word waits for its acknowledge");
      end
    end
    core_up_ack = 1'b1;
    next_cycle();
    core_up_ack = 1'b0;
  endtask

  task automatic run_downlink();
    fork
      begin
        for (int i = 0; i < N_WORDS; i++) begin
          offer_word($urandom % 4);
        end
      end
      begin
        for (int i = 0; i < N_WORDS; i++) begin
          take_down_word(1, $urandom % 5);
        end
      end
    join
    if (down_q.size() != 0) begin
      note_failure(1, "acknowledged downlink words never reached the pins");
    end
    if (pin_words != N_WORDS) begin
      note_mismatch(2, "down_pins.valid rises", 64'(pin_words), 64'(N_WORDS));
    end
  endtask

  task automatic run_uplink();
    fork
      begin
        for (int i = 0; i < N_WORDS; i++) begin
          drive_up_word($urandom % 4);
        end
      end
      begin
        for (int i = 0; i < N_WORDS; i++) begin
          accept_up_word($urandom % 6);
        end
      end
    join
    if (up_q.size() != 0) begin
      note_failure(4, "chip words never reached the core");
    end
  endtask

  // ready held low, FIFO plus transmitter fill up, then drain
  task automatic run_back_pressure();
    int acks;
    acks = 0;
    down_ready = 1'b0;
    fork
      begin
        for (int i = 0; i < BP_WORDS; i++) begin
          offer_word(0);
        end
      end
      begin
        repeat (BP_CYCLES) begin
          next_cycle();
          if (core_down_ack) acks++;
          if (down_pins.valid) begin
            note_failure(5, "downlink valid rose while ready was held low");
          end
        end
        if (acks != FIFO_DEPTH + 1) begin
          note_mismatch(5, "core_down_ack count", 64'(acks), 64'(FIFO_DEPTH + 1));
        end
        for (int i = 0; i < BP_WORDS; i++) begin
          take_down_word(5, $urandom % 3);
        end
      end
    join
    if (down_q.size() != 0) begin
      note_failure(5, "words left behind after the drain");
    end
  endtask

  task automatic print_result(input int test_id, input string name);
    if (test_errs[test_id] == 0) begin
      $display("test %0d %s: ok", test_id, name);
    end else begin
      $display("test %0d %s: FAILED, %0d errors", test_id, name, test_errs[test_id]);
      failed++;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    errors      = 0;
    failed      = 0;
    pin_words   = 0;
    valid_seen  = 1'b0;
    foreach (test_errs[i]) test_errs[i] = 0;
    reset       = 1'b1;
    core_down   = '0;
    core_up_ack = 1'b0;
    down_ready  = 1'b0;
    up_pins     = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    fork
      begin
        run_downlink();
        print_result(1, "downlink order and data");
        print_result(2, "downlink handshake");
      end
      begin
        check_startup(); // starts right at reset release
        print_result(3, "uplink startup");
        run_uplink();
        print_result(4, "uplink order and data");
      end
    join
    run_back_pressure();
    print_result(5, "downlink back-pressure");
    $display("tests 5, failed %0d, error count %0d", failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog, every word gets the worst case budget
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== test/pin_link_properties.sv ====
`timescale 1ns/1ns

module pin_link_properties (
  input logic                     clk,
  input logic                     reset,
  input pin_link_pkg::down_pins_t down_pins,
  input logic                     down_ready,
  input pin_link_pkg::up_pins_t   up_pins,
  input logic                     up_ready,
  input pin_link_pkg::up_chan_t   core_up,
  input logic                     core_up_ack
);

  // downlink, valid only rises after the chip raised ready
  valid_after_ready: assert property (@(posedge clk) disable iff (reset)
    $rose(down_pins.valid) |-> $past(down_ready))
    else $error("down_pins.valid rose without down_ready");

  // data frozen while valid is up
  data_stable: assert property (@(posedge clk) disable iff (reset)
    down_pins.valid |=> !down_pins.valid || $stable(down_pins.data))
    else $error("down_pins.data changed while valid was high");

  valid_falls_after_ready: assert property (@(posedge clk) disable iff (reset)
    $fell(down_pins.valid) |-> $past(!down_ready))
    else $error("down_pins.valid fell while down_ready was high");

  valid_drops_next: assert property (@(posedge clk) disable iff (reset)
    down_pins.valid && !down_ready |=> !down_pins.valid)
    else $error("down_pins.valid held after down_ready fell");

  // uplink, ready falls only on a capture and the core gets the pin word
  up_capture: assert property (@(posedge clk) disable iff (reset)
    $fell(up_ready) |-> core_up.v && (core_up.d == $past(up_pins.data)))
    else $error("up_ready fell without the chip word reaching core_up");

  up_hold: assert property (@(posedge clk) disable iff (reset)
    core_up.v && !core_up_ack |=> core_up.v && $stable(core_up.d))
    else $error("core_up word changed before its ack");

endmodule

bind pin_link_top pin_link_properties i_props (
  .clk         (clk),
  .reset       (reset),
  .down_pins   (down_pins),
  .down_ready  (down_ready),
  .up_pins     (up_pins),
  .up_ready    (up_ready),
  .core_up     (core_up),
  .core_up_ack (core_up_ack)
);

// ==== hdl/pin_link_top.sv ====
`timescale 1ns/1ns

module pin_link_top #(
  parameter int unsigned FIFO_DEPTH     = 4,    // downlink buffer entries
  parameter int unsigned STARTUP_CYCLES = 1000  // uplink ready hold-off
) (
  input  logic                     clk,
  input  logic                     reset,
  // downlink, core side
  input  pin_link_pkg::down_chan_t core_down,
  output logic                     core_down_ack,
  // downlink, chip side
  output pin_link_pkg::down_pins_t down_pins,
  input  logic                     down_ready,
  // uplink, chip side
  input  pin_link_pkg::up_pins_t   up_pins,
  output logic                     up_ready,
  // uplink, core side
  output pin_link_pkg::up_chan_t   core_up,
  input  logic                     core_up_ack
);

  import pin_link_pkg::*;

  down_chan_t fifo_chan; // FIFO head to transmitter
  logic       fifo_ack;  // transmitter took the head

  // downlink buffer, decouples the core from the chip handshake
  down_word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fifo (
    .clk      (clk),
    .reset    (reset),
    .in_chan  (core_down),
    .in_ack   (core_down_ack),
    .out_chan (fifo_chan),
    .out_ack  (fifo_ack)
  );

  // downlink pin transmitter
  core_to_pin i_tx (
    .clk       (clk),
    .reset     (reset),
    .word_chan (fifo_chan),
    .word_ack  (fifo_ack),
    .pins      (down_pins),
    .ready     (down_ready)
  );

  // uplink pin receiver, no buffer, the chip is stalled through up_ready
  pin_to_core #(
    .STARTUP_CYCLES (STARTUP_CYCLES)
  ) i_rx (
    .clk       (clk),
    .reset     (reset),
    .pins      (up_pins),
    .ready     (up_ready),
    .word_chan (core_up),
    .word_ack  (core_up_ack)
  );

endmodule

// ==== hdl/pin_to_core.sv ====
`timescale 1ns/1ns

module pin_to_core #(
  parameter int unsigned STARTUP_CYCLES = 1000 // ready hold-off after reset
) (
  input  logic                   clk,
  input  logic                   reset,
  input  pin_link_pkg::up_pins_t pins,      // from the chip
  output logic                   ready,     // up_ready to the chip
  output pin_link_pkg::up_chan_t word_chan, // to the core
  input  logic                   word_ack   // core takes the word
);

  import pin_link_pkg::*;

  localparam int HOLD_BITS = (STARTUP_CYCLES > 1) ? $clog2(STARTUP_CYCLES + 1) : 1;

  rx_state_t            state;
  rx_state_t            next_state;
  logic [UP_BITS-1:0]   data_q;      // captured chip word
  logic [HOLD_BITS-1:0] hold_cnt;    // startup hold-off, counts down to zero
  logic                 hold_done;
  logic                 phase;       // divided sampling phase
  logic                 sample;

  assign hold_done = (hold_cnt == '0);

  // capture only in the sampling half of the phase,
  // keeps the sample point away from the chip's own io clock edge
  assign sample = (state == rx_ready_high) && hold_done && phase && pins.valid;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state    <= rx_ready_high;
      hold_cnt <= HOLD_BITS'(STARTUP_CYCLES);
      phase    <= 1'b0;
    end else begin
      state <= next_state;
      phase <= ~phase; // free running toggle
      if (!hold_done) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
    end
  end

  // captured word, reset to zero so core_up reads clean before the first word
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      data_q <= '0;
    end else if (sample) begin
      data_q <= pins.data;
    end
  end

  // next state
  always_comb begin
    next_state = state;
    unique case (state)
      rx_ready_high: begin
        if (sample) begin
          next_state = rx_ready_low; // ready falls, chip releases valid
        end
      end
      rx_ready_low: begin
        // stays here with ready low until the core acks, stalls the chip
        if (word_ack) begin
          next_state = rx_ready_high;
        end
      end
      default: begin
        next_state = rx_ready_high;
      end
    endcase
  end

  // outputs decoded from state
  always_comb begin
    ready       = (state == rx_ready_high) && hold_done; // low during hold-off
    word_chan.v = (state == rx_ready_low);               // word held until ack
    word_chan.d = data_q;
  end

  // one word per visit to rx_ready_low, so one word per ack pulse

endmodule

// ==== hdl/core_to_pin.sv ====
`timescale 1ns/1ns

module core_to_pin (
  input  logic                     clk,
  input  logic                     reset,
  input  pin_link_pkg::down_chan_t word_chan, // from the FIFO
  output logic                     word_ack,  // one-cycle pulse per word taken
  output pin_link_pkg::down_pins_t pins,      // to the chip
  input  logic                     ready      // chip level handshake
);

  import pin_link_pkg::*;

  tx_state_t            state;
  tx_state_t            next_state;
  logic [DOWN_BITS-1:0] data_q;     // pin data register
  logic [DOWN_BITS-1:0] next_data;
  logic                 next_ack;

  // the word is registered one cycle before valid can rise,
  // so the data pins are already settled when valid goes high
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state    <= tx_idle;
      data_q   <= '0;
      word_ack <= 1'b0;
    end else begin
      state    <= next_state;
      data_q   <= next_data;
      word_ack <= next_ack; // pulse follows the load by one cycle
    end
  end

  // next state, ready is looked at in one place per state
  always_comb begin
    next_state = state;
    next_data  = data_q; // hold by default
    next_ack   = 1'b0;
    unique case (state)
      tx_idle: begin
        if (word_chan.v) begin // load and ack
          next_data  = word_chan.d;
          next_ack   = 1'b1;
          next_state = tx_valid_low;
        end
      end
      tx_valid_low: begin
        // waits here with data held for as long as the chip keeps ready low
        if (ready) begin
          next_state = tx_valid_high;
        end
      end
      tx_valid_high: begin
        if (!ready) begin
          // chip took the word, valid drops next cycle
          if (word_chan.v) begin
            next_data  = word_chan.d; // back to back load
            next_ack   = 1'b1;
            next_state = tx_valid_low;
          end else begin
            next_state = tx_idle;
          end
        end
      end
      default: begin
        next_state = tx_idle;
      end
    endcase
  end

  // pins
  always_comb begin
    pins.valid = (state == tx_valid_high); // decoded straight from state
    pins.data  = data_q;
  end

  // word_chan.v is ignored in tx_valid_low, the FIFO head moves during the
  // ack cycle and the new head is only looked at once ready has fallen

endmodule

// ==== hdl/down_word_fifo.sv ====
`timescale 1ns/1ns

module down_word_fifo #(
  parameter int unsigned FIFO_DEPTH = 4 // entries
) (
  input  logic                     clk,
  input  logic                     reset,
  input  pin_link_pkg::down_chan_t in_chan,  // from the core
  output logic                     in_ack,   // registered one-cycle pulse
  output pin_link_pkg::down_chan_t out_chan, // head word to the transmitter
  input  logic                     out_ack   // head word taken
);

  import pin_link_pkg::*;

  localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

  logic [DOWN_BITS-1:0] mem [FIFO_DEPTH]; // word storage, no reset
  logic [PTR_BITS-1:0]  wr_ptr;
  logic [PTR_BITS-1:0]  rd_ptr;
  logic [CNT_BITS-1:0]  count;            // occupancy
  logic                 push;
  logic                 pop;

  // take a word only when there is room and the previous ack is not still out,
  // the core keeps v high during the ack cycle so that word must not count twice
  assign push = in_chan.v && !in_ack && (count < CNT_BITS'(FIFO_DEPTH));
  assign pop  = out_ack && (count != '0); // transmitter acks only a valid head

  // write side
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_chan.d;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      in_ack <= 1'b0;
    end else begin
      in_ack <= push; // ack lands one cycle after the write
      if (push) begin
        // explicit wrap, depth need not fill the pointer range
        wr_ptr <= (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // occupancy, simultaneous push and pop leaves it alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head word is held as long as it sits at rd_ptr
  always_comb begin
    out_chan.v = (count != '0);
    out_chan.d = mem[rd_ptr];
  end

endmodule

// ==== hdl/pin_link_pkg.sv ====
`include "pin_widths.svh"

package pin_link_pkg;

  parameter int DOWN_BITS = `DOWN_BITS; // downlink word width
  parameter int UP_BITS   = `UP_BITS;   // uplink word width

  // core side channels, ack travels back as a separate bit
  typedef struct packed {
    logic                 v; // word valid, held until ack
    logic [DOWN_BITS-1:0] d; // word
  } down_chan_t;

  typedef struct packed {
    logic               v;
    logic [UP_BITS-1:0] d;
  } up_chan_t;

  // chip pins, ready runs as its own wire
  typedef struct packed {
    logic                 valid; // high only while data is stable
    logic [DOWN_BITS-1:0] data;
  } down_pins_t;

  typedef struct packed {
    logic               valid; // chip holds it until up_ready falls
    logic [UP_BITS-1:0] data;
  } up_pins_t;

  // transmitter states
  typedef enum logic [1:0] {
    tx_idle,       // nothing registered
    tx_valid_low,  // word registered, waiting for ready
    tx_valid_high  // valid on the pins, waiting for ready to drop
  } tx_state_t;

  typedef enum logic {rx_ready_high, rx_ready_low} rx_state_t; // receiver states

endpackage

// ==== include/pin_widths.svh ====
`ifndef PIN_WIDTHS_SVH
`define PIN_WIDTHS_SVH

// word widths on the chip pins
`define DOWN_BITS 21 // core -> chip word
`define UP_BITS   34 // chip -> core word

// both directions are plain words, no framing bits

`endif
